//--- sources.f
+incdir+include
hdl/ecc_pkg.sv
hdl/rel_pkg.sv
hdl/secded_encoder.sv
hdl/tmr_fifo.sv
hdl/secded_decoder.sv
hdl/rel_fifo_top.sv
testbench/tb_rel_fifo_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log.

LOG=sim.log

verilator --binary --assert --top-module tb_rel_fifo_top -f sources.f -o sim_tb \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

# a crash or stopped assertion counts as a failure too
./obj_dir/sim_tb > "$LOG" 2>&1 || echo "Something failed" >> "$LOG"

cat "$LOG"

! grep -q "Something failed" "$LOG" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- testbench/tb_rel_fifo_top.sv
/*
 * Protected queue testbench
 * Table of push, pop, flush and injection steps applied in a loop, with
 * a reference queue and the expected SEC-DED status taken from the
 * weight of the injected mask
 */

`timescale 1ns/1ps

module tb_rel_fifo_top;

  localparam int unsigned DW = ecc_pkg::DataWidth;
  localparam int unsigned CW = $bits(ecc_pkg::codeword_t);

  typedef logic [rel_pkg::AddrWidth:0] usage_t;

  // one row of stimulus
  typedef struct packed {
    rel_pkg::tmr_strobe_t push;
    rel_pkg::tmr_strobe_t pop;
    logic                 flush;
    logic                 rnd;
    logic [DW-1:0]        data;
    ecc_pkg::codeword_t   inject;
  } step_t;

  // word held by the reference queue, with the mask it was pushed with
  typedef struct packed {
    logic [DW-1:0]      data;
    ecc_pkg::codeword_t inject;
  } entry_t;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 flush_i;
  logic [DW-1:0]        wdata_i;
  ecc_pkg::codeword_t   inject_i;
  rel_pkg::tmr_strobe_t push_i;
  rel_pkg::tmr_strobe_t pop_i;
  logic [DW-1:0]        rdata_o;
  ecc_pkg::dec_status_e rstatus_o;
  logic                 rvalid_o;
  logic                 full_o;
  logic                 empty_o;
  usage_t               usage_o;
  logic                 fault_o;

  step_t  steps[$];
  entry_t model_q[$];
  integer seed;
  int     errors;
  int     cycles;
  int     cycle_limit;

  rel_fifo_top rel_fifo_top_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_i   (flush_i),
    .wdata_i   (wdata_i),
    .inject_i  (inject_i),
    .push_i    (push_i),
    .pop_i     (pop_i),
    .rdata_o   (rdata_o),
    .rstatus_o (rstatus_o),
    .rvalid_o  (rvalid_o),
    .full_o    (full_o),
    .empty_o   (empty_o),
    .usage_o   (usage_o),
    .fault_o   (fault_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // run limit scales with the table
  always @(posedge clk_i) begin : watchdog
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("run stopped: no end of test after %0d cycles", cycles);
      $display("Something failed");
      $finish;
    end
  end

  // two out of three copies high
  function automatic logic votes(input rel_pkg::tmr_strobe_t s);
    return ($countones(s) >= 2);
  endfunction

  // all copies agree
  function automatic logic uniform(input rel_pkg::tmr_strobe_t s);
    return (s == '0) || (s == '1);
  endfunction

  function automatic ecc_pkg::codeword_t bit_mask(input int unsigned b);
    logic [CW-1:0] m;
    m    = '0;
    m[b] = 1'b1;
    return m;
  endfunction

  task automatic check_word(input string name, input logic [DW-1:0] exp,
                            input logic [DW-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_status(input ecc_pkg::dec_status_e exp,
                              input ecc_pkg::dec_status_e act);
    if (act !== exp) begin
      $display("FAILED rstatus_o: expected %h, got %h", exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  // status flags against the reference queue
  task automatic check_flags(input logic exp_full, input logic exp_empty,
                             input usage_t exp_usage);
    check_bit("full_o", exp_full, full_o);
    check_bit("empty_o", exp_empty, empty_o);
    if (usage_o !== exp_usage) begin
      $display("FAILED usage_o: expected %h, got %h", exp_usage, usage_o);
      errors++;
    end
  endtask

  // mask weight decides the decoder result
  task automatic score_read(input entry_t ent);
    int unsigned weight;
    weight = $countones(ent.inject);
    if (weight == 0) begin
      check_word("rdata_o", ent.data, rdata_o);
      check_status(ecc_pkg::DEC_CLEAN, rstatus_o);
    end else if (weight == 1) begin
      check_word("rdata_o", ent.data, rdata_o);
      check_status(ecc_pkg::DEC_CORRECTED, rstatus_o);
    end else begin
      // double error passes the raw payload
      check_word("rdata_o", ent.data ^ ent.inject.data, rdata_o);
      check_status(ecc_pkg::DEC_UNCORRECTABLE, rstatus_o);
    end
  endtask

  task automatic add_step(input rel_pkg::tmr_strobe_t push, input rel_pkg::tmr_strobe_t pop,
                          input logic flush, input logic rnd, input logic [DW-1:0] data,
                          input ecc_pkg::codeword_t inject);
    step_t st;
    st.push   = push;
    st.pop    = pop;
    st.flush  = flush;
    st.rnd    = rnd;
    st.data   = data;
    st.inject = inject;
    steps.push_back(st);
  endtask

  task automatic build_table();
    // fill to full, then pop one and push with pop in one cycle
    for (int k = 0; k < rel_pkg::Depth; k++) begin
      add_step(3'b111, 3'b000, 1'b0, 1'b1, '0, '0);
    end
    add_step(3'b000, 3'b111, 1'b0, 1'b0, '0, '0);
    add_step(3'b111, 3'b111, 1'b0, 1'b1, '0, '0);
    for (int k = 0; k < rel_pkg::Depth - 1; k++) begin
      add_step(3'b000, 3'b111, 1'b0, 1'b0, '0, '0);
    end
    // single upset at every codeword bit
    for (int unsigned b = 0; b < CW; b++) begin
      add_step(3'b111, 3'b000, 1'b0, 1'b1, '0, bit_mask(b));
      add_step(3'b000, 3'b111, 1'b0, 1'b0, '0, '0);
    end
    // double upsets in data, parity and across both
    add_step(3'b111, 3'b000, 1'b0, 1'b1, '0, bit_mask(0) | bit_mask(1));
    add_step(3'b111, 3'b000, 1'b0, 1'b1, '0, bit_mask(5) | bit_mask(32));
    add_step(3'b111, 3'b000, 1'b0, 1'b1, '0, bit_mask(33) | bit_mask(38));
    add_step(3'b111, 3'b000, 1'b0, 1'b0, 32'hdead_beef, bit_mask(31) | bit_mask(20));
    for (int k = 0; k < 4; k++) begin
      add_step(3'b000, 3'b111, 1'b0, 1'b0, '0, '0);
    end
    // one disagreeing copy per strobe
    add_step(3'b011, 3'b000, 1'b0, 1'b1, '0, '0);
    add_step(3'b101, 3'b000, 1'b0, 1'b1, '0, '0);
    add_step(3'b001, 3'b000, 1'b0, 1'b1, '0, '0);
    add_step(3'b110, 3'b000, 1'b0, 1'b1, '0, '0);
    add_step(3'b000, 3'b011, 1'b0, 1'b0, '0, '0);
    add_step(3'b000, 3'b100, 1'b0, 1'b0, '0, '0);
    add_step(3'b000, 3'b101, 1'b0, 1'b0, '0, '0);
    add_step(3'b000, 3'b110, 1'b0, 1'b0, '0, '0);
    // flush overrides push and pop, later words come out next
    for (int k = 0; k < 3; k++) begin
      add_step(3'b111, 3'b000, 1'b0, 1'b1, '0, '0);
    end
    add_step(3'b111, 3'b111, 1'b1, 1'b1, '0, '0);
    add_step(3'b111, 3'b000, 1'b0, 1'b0, 32'h0123_4567, '0);
    add_step(3'b111, 3'b000, 1'b0, 1'b1, '0, '0);
    add_step(3'b000, 3'b111, 1'b0, 1'b0, '0, '0);
    add_step(3'b000, 3'b111, 1'b0, 1'b0, '0, '0);
  endtask

  initial begin : main
    step_t         st;
    entry_t        ent;
    entry_t        ent_new;
    logic [DW-1:0] word;
    logic          can_push;
    logic          can_pop;
    logic          exp_fault;
    logic          exp_rvalid;
    seed        = 32'h574a;
    errors      = 0;
    cycles      = 0;
    cycle_limit = 0;
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    wdata_i     = '0;
    inject_i    = '0;
    push_i      = '0;
    pop_i       = '0;
    ent         = '0;
    build_table();
    cycle_limit = steps.size() * 4 + 100;

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_flags(1'b0, 1'b1, '0);
    check_bit("fault_o", 1'b0, fault_o);
    check_bit("rvalid_o", 1'b0, rvalid_o);

    foreach (steps[i]) begin
      st   = steps[i];
      word = st.rnd ? $random(seed) : st.data;
      wdata_i  = word;
      inject_i = st.inject;
      push_i   = st.push;
      pop_i    = st.pop;
      flush_i  = st.flush;

      // state before the edge decides what each strobe may do
      can_push   = (model_q.size() < rel_pkg::Depth);
      can_pop    = (model_q.size() != 0);
      exp_fault  = (!uniform(st.push) && can_push) || (!uniform(st.pop) && can_pop);
      exp_rvalid = 1'b0;
      #1;
      check_bit("fault_o", exp_fault, fault_o);

      if (st.flush) begin
        model_q.delete();
      end else begin
        if (votes(st.pop) && can_pop) begin
          ent        = model_q.pop_front();
          exp_rvalid = 1'b1;
        end
        if (votes(st.push) && can_push) begin
          ent_new.data   = word;
          ent_new.inject = st.inject;
          model_q.push_back(ent_new);
        end
      end

      // registered results settle by the next falling edge
      @(negedge clk_i);
      check_bit("rvalid_o", exp_rvalid, rvalid_o);
      if (exp_rvalid) begin
        score_read(ent);
      end
      check_flags(model_q.size() == rel_pkg::Depth, model_q.size() == 0,
                  usage_t'(model_q.size()));
    end

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- hdl/rel_fifo_top.sv
/*
 * Protected queue top level
 * Encoder, triplicated-control FIFO and decoder in a row, with all
 * voter mismatches merged into one fault flag
 */

`timescale 1ns/1ps

module rel_fifo_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  logic [ecc_pkg::DataWidth-1:0] wdata_i,
  input  ecc_pkg::codeword_t            inject_i,
  input  rel_pkg::tmr_strobe_t          push_i,
  input  rel_pkg::tmr_strobe_t          pop_i,
  output logic [ecc_pkg::DataWidth-1:0] rdata_o,
  output ecc_pkg::dec_status_e          rstatus_o,
  output logic                          rvalid_o,
  output logic                          full_o,
  output logic                          empty_o,
  output logic [rel_pkg::AddrWidth:0]   usage_o,
  output logic                          fault_o
);

  ecc_pkg::codeword_t  wr_cw;
  ecc_pkg::codeword_t  rd_cw;
  logic                rd_pop;
  rel_pkg::tmr_fault_t faults;

  // producer side
  secded_encoder secded_encoder_i (
    .wdata_i  (wdata_i),
    .inject_i (inject_i),
    .cw_o     (wr_cw)
  );

  tmr_fifo tmr_fifo_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .flush_i  (flush_i),
    .data_i   (wr_cw),
    .push_i   (push_i),
    .pop_i    (pop_i),
    .data_o   (rd_cw),
    .pop_o    (rd_pop),
    .full_o   (full_o),
    .empty_o  (empty_o),
    .usage_o  (usage_o),
    .faults_o (faults)
  );

  // consumer side, always ready
  secded_decoder secded_decoder_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .cw_i      (rd_cw),
    .pop_i     (rd_pop),
    .rdata_o   (rdata_o),
    .rstatus_o (rstatus_o),
    .rvalid_o  (rvalid_o)
  );

  // any voter mismatch
  assign fault_o = |faults;

endmodule

//--- hdl/secded_decoder.sv
/*
 * SEC-DED decoder
 * Recomputes the Hsiao syndrome of a popped codeword, corrects a
 * single-bit error, flags a double-bit error and registers the word,
 * the status and a valid pulse on each pop
 */

`timescale 1ns/1ps

module secded_decoder (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  ecc_pkg::codeword_t            cw_i,
  input  logic                          pop_i,
  output logic [ecc_pkg::DataWidth-1:0] rdata_o,
  output ecc_pkg::dec_status_e          rstatus_o,
  output logic                          rvalid_o
);

  logic [ecc_pkg::ParityWidth-1:0] syndrome;
  logic [ecc_pkg::DataWidth-1:0]   corr_data;
  ecc_pkg::dec_status_e            status;

  always_comb begin : calc_syndrome
    logic [ecc_pkg::ParityWidth-1:0] parity;
    parity = '0;
    for (int unsigned j = 0; j < ecc_pkg::DataWidth; j++) begin
      parity = parity ^ ({ecc_pkg::ParityWidth{cw_i.data[j]}} & ecc_pkg::HsiaoCols[j]);
    end
    // stored against recomputed check bits
    syndrome = parity ^ cw_i.parity;
  end

  always_comb begin : correct
    corr_data = cw_i.data;
    status    = ecc_pkg::DEC_CLEAN;
    if (syndrome != '0) begin
      if (!(^syndrome)) begin
        // even weight means two flipped bits and the raw data goes through
        status = ecc_pkg::DEC_UNCORRECTABLE;
      end else if ((syndrome & (syndrome - 1'b1)) == '0) begin
        // single check bit hit so the payload is intact
        status = ecc_pkg::DEC_CORRECTED;
      end else begin
        // odd weight with no matching column stays uncorrectable
        status = ecc_pkg::DEC_UNCORRECTABLE;
        for (int unsigned j = 0; j < ecc_pkg::DataWidth; j++) begin
          if (syndrome == ecc_pkg::HsiaoCols[j]) begin
            corr_data[j] = ~cw_i.data[j];
            status       = ecc_pkg::DEC_CORRECTED;
          end
        end
      end
    end
  end

  // valid pulse and status
  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
    if (!rst_ni) begin
      rvalid_o  <= 1'b0;
      rstatus_o <= ecc_pkg::DEC_CLEAN;
    end else begin
      rvalid_o <= pop_i;
      if (pop_i) begin
        rstatus_o <= status;
      end
    end
  end

  always_ff @(posedge clk_i) begin : data_regs
    if (pop_i) begin
      rdata_o <= corr_data;
    end
  end

  // correction flips at most one payload bit
  single_flip : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_o |-> ($countones(rdata_o ^ $past(cw_i.data)) <= 1))
    else $error("correction changed more than one payload bit");

endmodule

//--- hdl/tmr_fifo.sv
/*
 * TMR FIFO
 * Eight-entry codeword queue whose push and pop strobes, pointers and
 * memory next-state are kept in three copies and reduced by majority
 * vote before the registers. Status flags and head word are voted to
 * one value each, and every voter reports a mismatch flag
 */

`timescale 1ns/1ps

`include "voters.svh"

module tmr_fifo (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  ecc_pkg::codeword_t            data_i,
  input  rel_pkg::tmr_strobe_t          push_i,
  input  rel_pkg::tmr_strobe_t          pop_i,
  output ecc_pkg::codeword_t            data_o,
  output logic                          pop_o,
  output logic                          full_o,
  output logic                          empty_o,
  output logic [rel_pkg::AddrWidth:0]   usage_o,
  output rel_pkg::tmr_fault_t           faults_o
);

  // pointer with one wrap bit above the index
  typedef logic [rel_pkg::AddrWidth:0] ptr_t;

  ptr_t [rel_pkg::NumCopies-1:0] rd_ptr_q, wr_ptr_q;
  ptr_t [rel_pkg::NumCopies-1:0] rd_ptr_n, wr_ptr_n;
  ptr_t rd_ptr_v, wr_ptr_v;

  logic [rel_pkg::NumCopies-1:0] full, empty;
  logic [rel_pkg::NumCopies-1:0] push_acc, pop_acc;

  // single storage array, written from the voted image
  ecc_pkg::codeword_t [rel_pkg::Depth-1:0] mem_q, mem_n;
  ecc_pkg::codeword_t [rel_pkg::NumCopies-1:0][rel_pkg::Depth-1:0] mem_n_tmr;
  logic mem_we;

  // head word as seen through each read pointer
  ecc_pkg::codeword_t [rel_pkg::NumCopies-1:0] data_out;

  // per-copy status and accepted strobes
  for (genvar i = 0; i < rel_pkg::NumCopies; i++) begin : gen_copy_status
    assign full[i]     = ((wr_ptr_q[i] - rd_ptr_q[i]) == rel_pkg::Depth[rel_pkg::AddrWidth:0]);
    assign empty[i]    = (wr_ptr_q[i] == rd_ptr_q[i]);
    // a copy only acts against its own full or empty
    assign push_acc[i] = push_i[i] & ~full[i];
    assign pop_acc[i]  = pop_i[i] & ~empty[i];
    assign data_out[i] = mem_q[rd_ptr_q[i][rel_pkg::AddrWidth-1:0]];
  end

  // next state of each copy, kept apart until the vote
  always_comb begin : next_state
    for (int unsigned i = 0; i < rel_pkg::NumCopies; i++) begin
      rd_ptr_n[i]  = rd_ptr_q[i];
      wr_ptr_n[i]  = wr_ptr_q[i];
      mem_n_tmr[i] = mem_q;
      if (push_acc[i]) begin
        mem_n_tmr[i][wr_ptr_q[i][rel_pkg::AddrWidth-1:0]] = data_i;
        // power-of-two depth wraps on its own
        wr_ptr_n[i] = wr_ptr_q[i] + 1'b1;
      end
      if (pop_acc[i]) begin
        rd_ptr_n[i] = rd_ptr_q[i] + 1'b1;
      end
    end
  end

  // voters
  assign rd_ptr_v = `VOTE3(rd_ptr_n);
  assign wr_ptr_v = `VOTE3(wr_ptr_n);
  assign mem_n    = `VOTE3(mem_n_tmr);
  assign data_o   = `VOTE3(data_out);
  assign full_o   = `VOTE3(full);
  assign empty_o  = `VOTE3(empty);

  // flush cancels the pop so the consumer sees nothing that cycle
  assign pop_o = `VOTE3(pop_acc) & ~flush_i;

  assign faults_o.data_out = `VOTE3F(data_out);
  assign faults_o.full     = `VOTE3F(full);
  assign faults_o.empty    = `VOTE3F(empty);
  assign faults_o.mem      = `VOTE3F(mem_n_tmr);
  assign faults_o.pointer  = `VOTE3F(rd_ptr_n) | `VOTE3F(wr_ptr_n);

  // fill level taken from copy 0 only
  assign usage_o = wr_ptr_q[0] - rd_ptr_q[0];

  // memory only clocks in when some copy writes
  assign mem_we = (|push_acc) & ~flush_i;

  // all three copies reload from the voted value
  always_ff @(posedge clk_i or negedge rst_ni) begin : ptr_regs
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
    end else begin
      rd_ptr_q <= {rel_pkg::NumCopies{rd_ptr_v}};
      wr_ptr_q <= {rel_pkg::NumCopies{wr_ptr_v}};
    end
  end

  always_ff @(posedge clk_i) begin : mem_regs
    if (mem_we) begin
      mem_q <= mem_n;
    end
  end

  // no copy may push into a full queue
  full_push : assert property (@(posedge clk_i) disable iff (!rst_ni)
    full_o |-> (push_i == '0))
    else $error("push while the FIFO is full");

  // no copy may pop from an empty queue
  empty_pop : assert property (@(posedge clk_i) disable iff (!rst_ni)
    empty_o |-> (pop_i == '0))
    else $error("pop while the FIFO is empty");

  // fill level never passes the depth
  usage_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    usage_o <= rel_pkg::Depth[rel_pkg::AddrWidth:0])
    else $error("FIFO usage above its depth");

endmodule

//--- hdl/secded_encoder.sv
/*
 * SEC-DED encoder
 * Computes the seven Hsiao check bits of a 32-bit word and XORs a
 * fault-injection mask onto the complete codeword
 */

`timescale 1ns/1ps

module secded_encoder (
  input  logic [ecc_pkg::DataWidth-1:0] wdata_i,
  input  ecc_pkg::codeword_t            inject_i,
  output ecc_pkg::codeword_t            cw_o
);

  // codeword before injection
  ecc_pkg::codeword_t cw_raw;

  always_comb begin : calc_parity
    logic [ecc_pkg::ParityWidth-1:0] parity;
    parity = '0;
    // each data bit toggles the check bits of its column
    for (int unsigned j = 0; j < ecc_pkg::DataWidth; j++) begin
      parity = parity ^ ({ecc_pkg::ParityWidth{wdata_i[j]}} & ecc_pkg::HsiaoCols[j]);
    end
    cw_raw.parity = parity;
    cw_raw.data   = wdata_i;
  end

  // mask covers parity and data alike
  // a set bit flips that codeword bit exactly like an upset in storage
  assign cw_o = ecc_pkg::codeword_t'(cw_raw ^ inject_i);

endmodule

//--- hdl/rel_pkg.sv
/*
 * Reliability definitions
 * Queue geometry, the triplicated strobe type and the fault flags
 * reported by the voters of the buffer
 */

package rel_pkg;

  // number of redundant copies of every control signal
  localparam int unsigned NumCopies = 3;

  // queue geometry, depth is a power of two
  localparam int unsigned Depth     = 8;
  localparam int unsigned AddrWidth = 3;

  // one bit per copy of a push or pop strobe
  typedef logic [NumCopies-1:0] tmr_strobe_t;

  // mismatch seen by each voter group
  typedef struct packed {
    // head word read by the three copies
    logic data_out;
    logic full;
    logic empty;
    // memory next-state images
    logic mem;
    // read or write next pointers
    logic pointer;
  } tmr_fault_t;

endpackage

//--- hdl/ecc_pkg.sv
/*
 * ECC definitions
 * Widths, codeword layout, decoder status encoding and the column
 * table of the (39,32) Hsiao SEC-DED code
 */

package ecc_pkg;

  // payload and check bit counts
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned ParityWidth = 7;

  // check bits sit above the payload
  typedef struct packed {
    logic [ParityWidth-1:0] parity;
    logic [DataWidth-1:0]   data;
  } codeword_t;

  // decode result, registered together with the data word
  typedef enum logic [1:0] {
    DEC_CLEAN         = 2'b00,
    DEC_CORRECTED     = 2'b01,
    DEC_UNCORRECTABLE = 2'b10
  } dec_status_e;

  // one column per data bit, all of weight three and all distinct
  // check bit k covers data bit j when bit k of column j is set
  // weight-one syndromes are left to the check bits themselves
  localparam logic [ParityWidth-1:0] HsiaoCols [DataWidth] = '{
    7'h07, 7'h0b, 7'h13, 7'h23, 7'h43, 7'h0d, 7'h15, 7'h25,
    7'h45, 7'h19, 7'h29, 7'h49, 7'h31, 7'h51, 7'h61, 7'h0e,
    7'h16, 7'h26, 7'h46, 7'h1a, 7'h2a, 7'h4a, 7'h32, 7'h52,
    7'h62, 7'h1c, 7'h2c, 7'h4c, 7'h34, 7'h54, 7'h64, 7'h38
  };

endpackage

//--- include/voters.svh
/*
 * Triple modular redundancy voters
 * Expression macros for a three-copy packed vector: a bitwise majority
 * and a flag that is set when any bit of the copies disagrees
 */

`ifndef VOTERS_SVH
`define VOTERS_SVH

// bitwise two-out-of-three majority
// argument is a packed array whose outer dimension is [2:0]
// the result has the width of one copy
`define VOTE3(copies) \
  ((copies[0] & copies[1]) | \
   (copies[0] & copies[2]) | \
   (copies[1] & copies[2]))

// mismatch flag over all bits of the three copies
// one bit, high when at least one copy differs from another
// a single upset copy always shows up here, even when the vote masks it
`define VOTE3F(copies) \
  (|((copies[0] ^ copies[1]) | \
     (copies[1] ^ copies[2])))

`endif
